//--- hw/cpuPkg.sv
// Shared widths, opcode encodings and the structs that travel between the pipeline
// stages and over the instruction and data Wishbone buses.
// Modules refer to everything here by scoped name.
package cpuPkg;

	parameter int DataWidth = 16;
	parameter int RegAddrWidth = 3;

	// Every instruction is one 16-bit word
	parameter logic [DataWidth-1:0] InstrBytes = 2;

	// Kept opcodes, valued as they appear in instruction bits 15:11
	typedef enum logic [4:0] {
		opHalt  = 5'b00000,
		opNop   = 5'b00001,
		opAddi  = 5'b01000,
		opSubi  = 5'b01001,
		opBeqz  = 5'b01100,
		opBnez  = 5'b01101,
		opSt    = 5'b10000,
		opLd    = 5'b10001,
		opAluRR = 5'b11011
	} opcode_t;

	// Register-register function from bits 1:0
	typedef enum logic [1:0] {
		aluAdd  = 2'b00,
		aluSub  = 2'b01,
		aluXor  = 2'b10,
		aluAndn = 2'b11
	} aluOp_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [DataWidth-1:0] adr;
		logic [DataWidth-1:0] datW;
	} wbReq_t;

	typedef struct packed {
		logic ack;
		logic [DataWidth-1:0] datR;
	} wbRsp_t;

	// Writeback port, also used for both forwarding paths
	typedef struct packed {
		logic en;
		logic [RegAddrWidth-1:0] addr;
		logic [DataWidth-1:0] data;
	} regWrite_t;

	typedef struct packed {
		logic valid;
		logic [DataWidth-1:0] pc;
		opcode_t opcode;
		aluOp_t aluFn;
		logic [RegAddrWidth-1:0] rs;
		logic [RegAddrWidth-1:0] rt;
		logic [DataWidth-1:0] rsVal;
		logic [DataWidth-1:0] rtVal;
		logic [DataWidth-1:0] imm;
		logic [RegAddrWidth-1:0] rd;
		logic regWe;
		logic isLoad;
		logic isStore;
		logic isBranch;
		logic isHalt;
		logic isIllegal;
	} idEx_t;

	typedef struct packed {
		logic valid;
		logic [DataWidth-1:0] result;
		logic [DataWidth-1:0] storeData;
		logic [RegAddrWidth-1:0] dest;
		logic regWe;
		logic isLoad;
		logic isStore;
		logic isHalt;
		logic isIllegal;
	} exMem_t;

	// stop set means halt or illegal opcode, fetch ends for good
	typedef struct packed {
		logic valid;
		logic stop;
		logic [DataWidth-1:0] target;
	} redirect_t;

endpackage

//--- hw/fetchStage.sv
`timescale 1ns/1ps
// Fetch stage: PC, Wishbone read master for instructions and a one-entry buffer.
// Also produces the single advance strobe that moves every pipeline register.
module fetchStage #(
	parameter logic [cpuPkg::DataWidth-1:0] ResetPc = '0
) (
	input  logic clk,
	input  logic arstN,
	input  logic holdFetch,
	input  logic memBusy,
	input  cpuPkg::redirect_t redirect,
	input  cpuPkg::wbRsp_t iBusRsp,
	output cpuPkg::wbReq_t iBusReq,
	output logic [cpuPkg::DataWidth-1:0] fetchedInstr,
	output logic [cpuPkg::DataWidth-1:0] fetchedPc,
	output logic fetchedValid,
	output logic advance
);

	logic [cpuPkg::DataWidth-1:0] pc;
	logic [cpuPkg::DataWidth-1:0] reqAdr;
	logic [cpuPkg::DataWidth-1:0] fetchAddr;
	logic [cpuPkg::DataWidth-1:0] bufInstr;
	logic [cpuPkg::DataWidth-1:0] bufPc;
	logic bufValid;
	logic busCyc;
	logic stopped;
	logic ackNow;
	logic consume;
	logic startReq;

	// Once stopped, bubbles keep flowing so the stop instruction can retire
	assign advance = (bufValid || stopped) && !memBusy;
	assign consume = advance && !holdFetch;
	assign ackNow = busCyc && iBusRsp.ack;
	assign fetchAddr = redirect.valid ? redirect.target : pc;

	// Only start a read when the buffer is sure to be empty by the time ack lands
	assign startReq = !busCyc && !stopped && !(redirect.valid && redirect.stop) &&
		(!bufValid || consume || redirect.valid);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= ResetPc;
			busCyc <= 1'b0;
			stopped <= 1'b0;
			bufValid <= 1'b0;
		end else begin
			if (startReq) begin
				busCyc <= 1'b1;
				pc <= fetchAddr + cpuPkg::InstrBytes;
			end else if (redirect.valid) begin
				pc <= redirect.target;
			end
			if (ackNow) begin
				busCyc <= 1'b0;
			end
			if (redirect.valid && redirect.stop) begin
				stopped <= 1'b1;
			end
			// A redirect needs a full buffer and thus never meets a read in flight
			if (redirect.valid) begin
				bufValid <= 1'b0;
			end else if (ackNow) begin
				bufValid <= 1'b1;
			end else if (consume) begin
				bufValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (startReq) begin
			reqAdr <= fetchAddr;
		end
		if (ackNow) begin
			bufInstr <= iBusRsp.datR;
			bufPc <= reqAdr;
		end
	end

	// Read-only master
	always_comb begin
		iBusReq.cyc = busCyc;
		iBusReq.stb = busCyc;
		iBusReq.we = 1'b0;
		iBusReq.adr = reqAdr;
		iBusReq.datW = '0;
	end

	assign fetchedInstr = bufInstr;
	assign fetchedPc = bufPc;
	assign fetchedValid = bufValid;

endmodule

//--- hw/decodeStage.sv
`timescale 1ns/1ps
// Decode stage: IF/ID register, instruction decoder, register file and the
// load-use check. The decoded instruction leaves as idExNext, which the
// execute stage latches on advance.
module decodeStage (
	input  logic clk,
	input  logic arstN,
	input  logic advance,
	input  logic [cpuPkg::DataWidth-1:0] fetchedInstr,
	input  logic [cpuPkg::DataWidth-1:0] fetchedPc,
	input  logic fetchedValid,
	input  cpuPkg::redirect_t redirect,
	input  cpuPkg::regWrite_t wbWrite,
	input  logic [cpuPkg::RegAddrWidth-1:0] idExLoadDest,
	input  logic idExIsLoad,
	output logic holdFetch,
	output cpuPkg::idEx_t idExNext
);

	localparam int RegCount = 1 << cpuPkg::RegAddrWidth;
	localparam int DW = cpuPkg::DataWidth;

	logic ifIdValid;
	logic [DW-1:0] ifIdInstr;
	logic [DW-1:0] ifIdPc;
	logic [DW-1:0] regs [RegCount];
	logic [cpuPkg::RegAddrWidth-1:0] rs;
	logic [cpuPkg::RegAddrWidth-1:0] rt;
	logic [DW-1:0] rsVal;
	logic [DW-1:0] rtVal;
	logic [DW-1:0] imm5;
	logic [DW-1:0] imm8;
	logic usesRs;
	logic usesRt;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ifIdValid <= 1'b0;
		end else if (advance) begin
			if (redirect.valid) begin
				ifIdValid <= 1'b0;
			end else if (!holdFetch) begin
				ifIdValid <= fetchedValid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance && !holdFetch) begin
			ifIdInstr <= fetchedInstr;
			ifIdPc <= fetchedPc;
		end
	end

	// Registers start at zero after reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < RegCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite.en) begin
			regs[wbWrite.addr] <= wbWrite.data;
		end
	end

	assign rs = ifIdInstr[10:8];
	assign rt = ifIdInstr[7:5];

	// A write in this cycle wins over the stored value
	assign rsVal = (wbWrite.en && wbWrite.addr == rs) ? wbWrite.data : regs[rs];
	assign rtVal = (wbWrite.en && wbWrite.addr == rt) ? wbWrite.data : regs[rt];

	assign imm5 = {{(DW - 5){ifIdInstr[4]}}, ifIdInstr[4:0]};
	assign imm8 = {{(DW - 8){ifIdInstr[7]}}, ifIdInstr[7:0]};

	always_comb begin
		idExNext = '0;
		idExNext.pc = ifIdPc;
		idExNext.rs = rs;
		idExNext.rt = rt;
		idExNext.rsVal = rsVal;
		idExNext.rtVal = rtVal;
		idExNext.imm = imm5;
		idExNext.rd = ifIdInstr[7:5];
		idExNext.opcode = cpuPkg::opNop;
		idExNext.aluFn = cpuPkg::aluAdd;
		usesRs = 1'b0;
		usesRt = 1'b0;
		case (ifIdInstr[15:11])
			cpuPkg::opHalt: begin
				idExNext.opcode = cpuPkg::opHalt;
				idExNext.isHalt = 1'b1;
			end
			cpuPkg::opNop: idExNext.opcode = cpuPkg::opNop;
			cpuPkg::opAddi, cpuPkg::opSubi: begin
				idExNext.opcode = cpuPkg::opcode_t'(ifIdInstr[15:11]);
				idExNext.aluFn = ifIdInstr[11] ? cpuPkg::aluSub : cpuPkg::aluAdd;
				idExNext.regWe = 1'b1;
				usesRs = 1'b1;
			end
			cpuPkg::opBeqz, cpuPkg::opBnez: begin
				idExNext.opcode = cpuPkg::opcode_t'(ifIdInstr[15:11]);
				idExNext.imm = imm8;
				idExNext.isBranch = 1'b1;
				usesRs = 1'b1;
			end
			cpuPkg::opSt: begin
				// Store data comes from bits 7:5
				idExNext.opcode = cpuPkg::opSt;
				idExNext.isStore = 1'b1;
				usesRs = 1'b1;
				usesRt = 1'b1;
			end
			cpuPkg::opLd: begin
				idExNext.opcode = cpuPkg::opLd;
				idExNext.isLoad = 1'b1;
				idExNext.regWe = 1'b1;
				usesRs = 1'b1;
			end
			cpuPkg::opAluRR: begin
				idExNext.opcode = cpuPkg::opAluRR;
				idExNext.aluFn = cpuPkg::aluOp_t'(ifIdInstr[1:0]);
				idExNext.rd = ifIdInstr[4:2];
				idExNext.regWe = 1'b1;
				usesRs = 1'b1;
				usesRt = 1'b1;
			end
			default: idExNext.isIllegal = 1'b1;
		endcase
		// Load result not ready yet, so hold IF/ID and send a bubble
		holdFetch = ifIdValid && idExIsLoad &&
			((usesRs && rs == idExLoadDest) || (usesRt && rt == idExLoadDest));
		idExNext.valid = ifIdValid && !holdFetch && !redirect.valid;
	end

endmodule

//--- hw/executeStage.sv
`timescale 1ns/1ps
// Execute stage: ID/EX register, operand forwarding, ALU and branch resolution.
// Taken branches, halt and illegal opcodes raise redirect toward fetch and decode.
module executeStage (
	input  logic clk,
	input  logic arstN,
	input  logic advance,
	input  cpuPkg::idEx_t idExNext,
	input  cpuPkg::regWrite_t exMemFwd,
	input  cpuPkg::regWrite_t memWbFwd,
	output logic [cpuPkg::RegAddrWidth-1:0] idExLoadDest,
	output logic idExIsLoad,
	output cpuPkg::redirect_t redirect,
	output cpuPkg::exMem_t exMemNext
);

	cpuPkg::idEx_t idEx;
	logic [cpuPkg::DataWidth-1:0] rsFwd;
	logic [cpuPkg::DataWidth-1:0] rtFwd;
	logic [cpuPkg::DataWidth-1:0] opB;
	logic [cpuPkg::DataWidth-1:0] aluOut;
	logic useImm;
	logic rsZero;
	logic taken;

	// Newest producer first, then the older one, then the register file value
	function automatic logic [cpuPkg::DataWidth-1:0] pickOperand(
		input logic [cpuPkg::RegAddrWidth-1:0] idx,
		input logic [cpuPkg::DataWidth-1:0] regVal,
		input cpuPkg::regWrite_t nearer,
		input cpuPkg::regWrite_t older
	);
		if (nearer.en && nearer.addr == idx) begin
			return nearer.data;
		end
		if (older.en && older.addr == idx) begin
			return older.data;
		end
		return regVal;
	endfunction

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			idEx <= '0;
		end else if (advance) begin
			idEx <= idExNext;
		end
	end

	assign rsFwd = pickOperand(idEx.rs, idEx.rsVal, exMemFwd, memWbFwd);
	assign rtFwd = pickOperand(idEx.rt, idEx.rtVal, exMemFwd, memWbFwd);

	assign useImm = idEx.opcode inside {cpuPkg::opAddi, cpuPkg::opSubi, cpuPkg::opLd,
		cpuPkg::opSt};
	assign opB = useImm ? idEx.imm : rtFwd;

	// sub is B minus A, so subi gives imm - Rs and the RR form gives Rt - Rs
	always_comb begin
		case (idEx.aluFn)
			cpuPkg::aluAdd:  aluOut = rsFwd + opB;
			cpuPkg::aluSub:  aluOut = opB - rsFwd;
			cpuPkg::aluXor:  aluOut = rsFwd ^ opB;
			cpuPkg::aluAndn: aluOut = rsFwd & ~opB;
		endcase
	end

	assign rsZero = (rsFwd == '0);
	assign taken = idEx.isBranch && ((idEx.opcode == cpuPkg::opBeqz) ? rsZero : !rsZero);

	// Issued together with advance so that fetch sees each redirect exactly once
	always_comb begin
		redirect.valid = idEx.valid && advance && (taken || idEx.isHalt || idEx.isIllegal);
		redirect.stop = idEx.isHalt || idEx.isIllegal;
		redirect.target = idEx.pc + cpuPkg::InstrBytes + idEx.imm;
	end

	always_comb begin
		exMemNext.valid = idEx.valid;
		exMemNext.result = aluOut;
		exMemNext.storeData = rtFwd;
		exMemNext.dest = idEx.rd;
		exMemNext.regWe = idEx.regWe;
		exMemNext.isLoad = idEx.isLoad;
		exMemNext.isStore = idEx.isStore;
		exMemNext.isHalt = idEx.isHalt;
		exMemNext.isIllegal = idEx.isIllegal;
	end

	// Seen by decode for the load-use check
	assign idExLoadDest = idEx.rd;
	assign idExIsLoad = idEx.valid && idEx.isLoad;

endmodule

//--- hw/memStage.sv
`timescale 1ns/1ps
// Memory and writeback stages: EX/MEM and MEM/WB registers and the Wishbone data
// master. memBusy freezes the whole pipeline until the data access is acked.
module memStage (
	input  logic clk,
	input  logic arstN,
	input  logic advance,
	input  cpuPkg::exMem_t exMemNext,
	input  cpuPkg::wbRsp_t dBusRsp,
	output cpuPkg::wbReq_t dBusReq,
	output logic memBusy,
	output cpuPkg::regWrite_t exMemFwd,
	output cpuPkg::regWrite_t memWbFwd,
	output cpuPkg::regWrite_t wbWrite,
	output logic halted,
	output logic err
);

	cpuPkg::exMem_t exMem;
	cpuPkg::regWrite_t memWb;
	logic memWbStop;
	logic memWbIllegal;
	logic [cpuPkg::DataWidth-1:0] loadData;
	logic [cpuPkg::DataWidth-1:0] loadValue;
	logic memOp;
	logic accDone;
	logic accGap;
	logic dCyc;
	logic dAck;

	assign memOp = exMem.valid && (exMem.isLoad || exMem.isStore);
	// accGap keeps cyc low for one cycle after an ack before the next access
	assign dCyc = memOp && !accDone && !accGap;
	assign dAck = dCyc && dBusRsp.ack;
	assign memBusy = memOp && !accDone && !dAck;
	assign loadValue = dAck ? dBusRsp.datR : loadData;

	always_comb begin
		dBusReq.cyc = dCyc;
		dBusReq.stb = dCyc;
		dBusReq.we = exMem.isStore;
		dBusReq.adr = exMem.result;
		dBusReq.datW = exMem.storeData;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exMem <= '0;
			memWb <= '0;
			memWbStop <= 1'b0;
			memWbIllegal <= 1'b0;
			accDone <= 1'b0;
			accGap <= 1'b0;
			halted <= 1'b0;
			err <= 1'b0;
		end else begin
			accGap <= dAck;
			if (advance) begin
				accDone <= 1'b0;
			end else if (dAck) begin
				// Acked but the pipeline cannot move yet
				accDone <= 1'b1;
			end
			if (advance) begin
				exMem <= exMemNext;
				memWb.en <= exMem.valid && exMem.regWe;
				memWb.addr <= exMem.dest;
				memWb.data <= exMem.isLoad ? loadValue : exMem.result;
				memWbStop <= exMem.valid && (exMem.isHalt || exMem.isIllegal);
				memWbIllegal <= exMem.valid && exMem.isIllegal;
				if (memWbStop) begin
					halted <= 1'b1;
					err <= memWbIllegal;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dAck) begin
			loadData <= dBusRsp.datR;
		end
	end

	// Load data only exists after MEM, so loads never forward from here
	always_comb begin
		exMemFwd.en = exMem.valid && exMem.regWe && !exMem.isLoad;
		exMemFwd.addr = exMem.dest;
		exMemFwd.data = exMem.result;
	end

	assign memWbFwd = memWb;
	assign wbWrite = memWb;

endmodule

//--- hw/proc.sv
`timescale 1ns/1ps
// Top level of the five-stage 16-bit processor. Connects fetch, decode,
// execute and memory/writeback; instructions and data come over two
// Wishbone classic master ports.
module proc #(
	parameter logic [cpuPkg::DataWidth-1:0] ResetPc = '0
) (
	input  logic clk,
	input  logic arstN,
	output cpuPkg::wbReq_t iBusReq,
	input  cpuPkg::wbRsp_t iBusRsp,
	output cpuPkg::wbReq_t dBusReq,
	input  cpuPkg::wbRsp_t dBusRsp,
	output logic halted,
	output logic err
);

	logic advance;
	logic holdFetch;
	logic memBusy;
	logic [cpuPkg::DataWidth-1:0] fetchedInstr;
	logic [cpuPkg::DataWidth-1:0] fetchedPc;
	logic fetchedValid;
	logic [cpuPkg::RegAddrWidth-1:0] idExLoadDest;
	logic idExIsLoad;
	cpuPkg::redirect_t redirect;
	cpuPkg::idEx_t idExNext;
	cpuPkg::exMem_t exMemNext;
	cpuPkg::regWrite_t exMemFwd;
	cpuPkg::regWrite_t memWbFwd;
	cpuPkg::regWrite_t wbWrite;

	fetchStage #(
		.ResetPc(ResetPc)
	) fetch (
		.clk, .arstN, .holdFetch, .memBusy, .redirect, .iBusRsp, .iBusReq,
		.fetchedInstr, .fetchedPc, .fetchedValid, .advance
	);

	decodeStage decode (
		.clk, .arstN, .advance, .fetchedInstr, .fetchedPc, .fetchedValid,
		.redirect, .wbWrite, .idExLoadDest, .idExIsLoad, .holdFetch, .idExNext
	);

	executeStage execute (
		.clk, .arstN, .advance, .idExNext, .exMemFwd, .memWbFwd,
		.idExLoadDest, .idExIsLoad, .redirect, .exMemNext
	);

	// Also holds the writeback register
	memStage mem (
		.clk, .arstN, .advance, .exMemNext, .dBusRsp, .dBusReq, .memBusy,
		.exMemFwd, .memWbFwd, .wbWrite, .halted, .err
	);

endmodule

//--- sim/proc_chk.sv
`timescale 1ns/1ps
// Wishbone protocol and reset checks for proc, attached by bind
module procChk (
	input logic clk,
	input logic arstN,
	input cpuPkg::wbReq_t iBusReq,
	input cpuPkg::wbRsp_t iBusRsp,
	input cpuPkg::wbReq_t dBusReq,
	input cpuPkg::wbRsp_t dBusRsp,
	input logic halted,
	input logic err
);

	iStbCyc: assert property (@(posedge clk) disable iff (!arstN)
		iBusReq.stb |-> iBusReq.cyc)
		else $error("instruction bus stb high without cyc");

	dStbCyc: assert property (@(posedge clk) disable iff (!arstN)
		dBusReq.stb |-> dBusReq.cyc)
		else $error("data bus stb high without cyc");

	// Request held until the slave acks
	iHold: assert property (@(posedge clk) disable iff (!arstN)
		(iBusReq.cyc && !iBusRsp.ack) |=> $stable(iBusReq))
		else $error("instruction bus request changed before ack");

	dHold: assert property (@(posedge clk) disable iff (!arstN)
		(dBusReq.cyc && !dBusRsp.ack) |=> $stable(dBusReq))
		else $error("data bus request changed before ack");

	resetQuiet: assert property (@(posedge clk)
		$rose(arstN) |-> (!iBusReq.cyc && !dBusReq.cyc && !halted && !err))
		else $error("bus cycle or status flag active right after reset");

	haltSticky: assert property (@(posedge clk) disable iff (!arstN)
		halted |=> halted)
		else $error("halted dropped without reset");

endmodule

bind proc procChk chk (
	.clk(clk), .arstN(arstN), .iBusReq(iBusReq), .iBusRsp(iBusRsp),
	.dBusReq(dBusReq), .dBusRsp(dBusRsp), .halted(halted), .err(err)
);

//--- sim/procTb.sv
`timescale 1ns/1ps
// Testbench for the pipelined processor. Reads programs, data and expected
// store traces from sim/procPatterns.hex, models the instruction and data
// memories as Wishbone slaves and compares every data write after halt.
// Run from the project root so the pattern path resolves.
module procTb;

	localparam int MemWords = 32768;
	localparam int PatWords = 512;
	localparam int DriveDelay = 5;
	localparam int SettleCycles = 20;

	logic clk;
	logic arstN;
	cpuPkg::wbReq_t iBusReq;
	cpuPkg::wbRsp_t iBusRsp;
	cpuPkg::wbReq_t dBusReq;
	cpuPkg::wbRsp_t dBusRsp;
	logic halted;
	logic err;

	logic [15:0] pat [PatWords];
	logic [15:0] imem [MemWords];
	logic [15:0] dmem [MemWords];
	logic [15:0] storeAdr [$];
	logic [15:0] storeDat [$];
	logic waitOn;
	int iWait;
	int dWait;
	int iWrites;
	int patPos;
	int passed;
	int failed;
	int budget = 0;

	proc #(
		.ResetPc(16'h0000)
	) UUT (
		.clk(clk), .arstN(arstN), .iBusReq(iBusReq), .iBusRsp(iBusRsp),
		.dBusReq(dBusReq), .dBusRsp(dBusRsp), .halted(halted), .err(err)
	);

	initial begin
		clk = 1'b0;
	end

	always #50 clk = ~clk;

	// 0 to 3 wait cycles per access when the test asks for them
	function automatic int pickWait();
		if (waitOn) begin
			return int'($urandom() % 32'd4);
		end
		return 0;
	endfunction

	// Watchdog length from the program sizes in the pattern file
	function automatic int computeBudget();
		int p;
		int cycles;
		int words;
		p = 1;
		cycles = 0;
		for (int t = 0; t < int'(pat[0]); t++) begin
			words = int'(pat[p + 2]);
			cycles += 200 * words * ((pat[p + 1] != 16'h0000) ? 4 : 1) + 50;
			p += 3 + words;
			p += 1 + int'(pat[p]);
			p += 1 + 2 * int'(pat[p]);
			p += 1;
		end
		return cycles;
	endfunction

	// Instruction memory, read only
	always @(posedge clk) begin
		#DriveDelay;
		if (!arstN || iBusRsp.ack) begin
			iBusRsp.ack = 1'b0;
		end else if (iBusReq.cyc && iBusReq.stb) begin
			if (iWait > 0) begin
				iWait--;
			end else begin
				if (iBusReq.we) begin
					iWrites++;
				end
				iBusRsp.ack = 1'b1;
				iBusRsp.datR = imem[iBusReq.adr[15:1]];
				iWait = pickWait();
			end
		end
	end

	// Data memory, every write is logged in order
	always @(posedge clk) begin
		#DriveDelay;
		if (!arstN || dBusRsp.ack) begin
			dBusRsp.ack = 1'b0;
		end else if (dBusReq.cyc && dBusReq.stb) begin
			if (dWait > 0) begin
				dWait--;
			end else begin
				dBusRsp.ack = 1'b1;
				if (dBusReq.we) begin
					dmem[dBusReq.adr[15:1]] = dBusReq.datW;
					storeAdr.push_back(dBusReq.adr);
					storeDat.push_back(dBusReq.datW);
				end else begin
					dBusRsp.datR = dmem[dBusReq.adr[15:1]];
				end
				dWait = pickWait();
			end
		end
	end

	task automatic runTest(input int num);
		logic [15:0] name;
		logic [15:0] expAdr;
		logic [15:0] expDat;
		logic expErr;
		int words;
		int nData;
		int nStores;
		int writesAtHalt;
		int bad;
		name = pat[patPos];
		waitOn = (pat[patPos + 1] != 16'h0000);
		words = int'(pat[patPos + 2]);
		patPos += 3;
		@(posedge clk);
		#DriveDelay;
		arstN = 1'b0;
		for (int i = 0; i < MemWords; i++) begin
			imem[i] = 16'h0000;
			dmem[i] = 16'(i) ^ 16'h5AC3;
		end
		for (int i = 0; i < words; i++) begin
			imem[i] = pat[patPos + i];
		end
		patPos += words;
		nData = int'(pat[patPos]);
		patPos += 1;
		for (int i = 0; i < nData; i++) begin
			dmem[i] = pat[patPos + i];
		end
		patPos += nData;
		repeat (10) @(posedge clk);
		#DriveDelay;
		storeAdr.delete();
		storeDat.delete();
		iWrites = 0;
		iWait = pickWait();
		dWait = pickWait();
		arstN = 1'b1;
		// Sample at the falling edge, away from the bus model updates
		while (halted !== 1'b1) begin
			@(negedge clk);
		end
		bad = 0;
		nStores = int'(pat[patPos]);
		patPos += 1;
		expErr = pat[patPos + 2 * nStores][0];
		if (err !== expErr) begin
			$display("ERROR test %0d: err expected %h got %h", num, expErr, err);
			bad++;
		end
		writesAtHalt = storeAdr.size();
		repeat (SettleCycles) @(negedge clk);
		if (halted !== 1'b1) begin
			$display("ERROR test %0d: halted expected %h got %h", num, 1'b1, halted);
			bad++;
		end
		if (err !== expErr) begin
			$display("ERROR test %0d: err expected %h got %h after halt", num, expErr, err);
			bad++;
		end
		if (storeAdr.size() != writesAtHalt) begin
			$display("Test %0d: the data bus wrote after the machine halted", num);
			bad++;
		end
		if (iWrites != 0) begin
			$display("Test %0d: the instruction bus issued a write cycle", num);
			bad++;
		end
		if (storeAdr.size() != nStores) begin
			$display("ERROR test %0d: store count expected %h got %h", num, nStores,
				storeAdr.size());
			bad++;
		end
		for (int i = 0; i < nStores && i < storeAdr.size(); i++) begin
			expAdr = pat[patPos + 2 * i];
			expDat = pat[patPos + 2 * i + 1];
			if (storeAdr[i] !== expAdr) begin
				$display("ERROR test %0d: dBusReq.adr of write %0d expected %h got %h",
					num, i, expAdr, storeAdr[i]);
				bad++;
			end
			if (storeDat[i] !== expDat) begin
				$display("ERROR test %0d: dBusReq.datW of write %0d expected %h got %h",
					num, i, expDat, storeDat[i]);
				bad++;
			end
		end
		patPos += 2 * nStores + 1;
		if (bad == 0) begin
			passed++;
			$display("Test %0d (code %h): pass, %0d writes", num, name, nStores);
		end else begin
			failed++;
			$display("Test %0d (code %h): FAIL with %0d mismatches", num, name, bad);
		end
	endtask

	initial begin
		int nTests;
		arstN = 1'b0;
		iBusRsp = '0;
		dBusRsp = '0;
		waitOn = 1'b0;
		iWait = 0;
		dWait = 0;
		iWrites = 0;
		passed = 0;
		failed = 0;
		void'($urandom(32'h2017_5a32));
		$readmemh("sim/procPatterns.hex", pat);
		nTests = int'(pat[0]);
		patPos = 1;
		budget = computeBudget();
		for (int t = 1; t <= nTests; t++) begin
			runTest(t);
		end
		$display("Tests run %0d, passed %0d, failed %0d", nTests, passed, failed);
		if (failed == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		wait (budget > 0);
		repeat (budget) @(posedge clk);
		$display("Timeout: halted did not rise within %0d cycles", budget);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- sim/procPatterns.hex
// Word 0 is the test count. Each test: name code, wait flag, program length, program,
// data length, data words, store count, store address/data pairs, expected err
0006
// 1 dependent arithmetic, both forwarding paths, every result stored
0001 0000
000F
4025 4143 496E DA70 D995 DD5A DC3F 80EE
80CC 80AA 8088 8066 8044 8022 0000
0000
0007
000E 0010 000C 0004 000A 000C 0008 0011
0006 0009 0004 0008 0002 0005
0000
// 2 load-use with an add and with store data
0002 0000
0006
8822 4147 8044 8866 8068 0000
0004
AAAA 1234 5555 0F0F
0002
0004 123B 0008 0F0F
0000
// 3 beqz and bnez taken and not taken, backward loop
0003 0000
0011
4021 6104 8022 6804 8024 6004 8026 8028
6904 802A 802C 802E 4044 824E 425E 6AFA
0000
0000
0005
0002 0001 0004 0001 000E 0001 0012 0004 0010 0002
0000
// 4 program of test 1 with wait states
0004 0001
000F
4025 4143 496E DA70 D995 DD5A DC3F 80EE
80CC 80AA 8088 8066 8044 8022 0000
0000
0007
000E 0010 000C 0004 000A 000C 0008 0011
0006 0009 0004 0008 0002 0005
0000
// 5 illegal opcode after a store
0005 0000
0005
4029 8022 F800 8024 0000
0000
0001
0002 0009
0001
// 6 halt with stores behind it
0006 0000
0005
4023 8022 0000 8024 8026
0000
0001
0002 0003
0000

//--- compile.f
hw/cpuPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memStage.sv
hw/proc.sv
sim/proc_chk.sv
sim/procTb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module procTb -f compile.f -o procSim
status=0
./obj_dir/procSim > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
	exit 1
fi
if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0
